// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_lsu
FILELIST  = sim.f
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | grep -F "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: lsu_cases.txt
# opcode funct3 rd imm rs1 rs2 rdata expected(wdata or rd_val) wstrb ld_mis st_mis
# All columns hex; rdata is the word the AXI slave returns for a load
23 0 00 000 00001000 A1B2C3D4 00000000 A1B2C3D4 1 0 0
23 0 00 001 00001000 A1B2C3D4 00000000 B2C3D400 2 0 0
03 0 01 000 00001000 00000000 F08172E3 FFFFFFE3 0 0 0
03 4 02 001 00001000 00000000 F08172E3 00000072 0 0 0
03 0 03 002 00001000 00000000 F08172E3 FFFFFF81 0 0 0
23 0 00 003 00001000 A1B2C3D4 00000000 D4000000 8 0 0
23 1 00 000 00001000 A1B2C3D4 00000000 A1B2C3D4 3 0 0
23 1 00 002 00001000 A1B2C3D4 00000000 C3D40000 C 0 0
03 1 05 000 00001000 00000000 F08172E3 000072E3 0 0 0
03 5 06 002 00001000 00000000 F08172E3 0000F081 0 0 0
23 1 00 001 00001000 A1B2C3D4 00000000 B2C3D400 6 0 1
03 2 08 000 00001000 00000000 F08172E3 F08172E3 0 0 0
03 2 09 001 00001000 00000000 F08172E3 F08172E3 0 1 0
03 1 0A 003 00001000 00000000 F08172E3 000000F0 0 1 0
03 5 0B 001 00001000 00000000 F08172E3 00008172 0 1 0
23 2 00 000 00001000 A1B2C3D4 00000000 A1B2C3D4 F 0 0
23 2 00 FFE 00001000 A1B2C3D4 00000000 C3D40000 C 0 1
03 0 0C 800 00001000 00000000 0000807F 0000007F 0 0 0
23 0 00 7FF 00001000 A1B2C3D4 00000000 D4000000 8 0 0

// File: lsu_issue_ctrl.sv
`timescale 1ns/1ps
/* LSU issue control: effective address, misalignment pulses,
   read/write direction ordering and routing to the load or store path */
module lsu_issue_ctrl (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               inst_valid,
    output logic               inst_ready,
    input  lsu_pkg::opcode_t   inst_opcode,
    input  lsu_pkg::funct3_t   inst_funct3,
    input  lsu_pkg::reg_addr_t inst_rd,
    input  lsu_pkg::imm12_t    inst_imm,
    input  lsu_pkg::xlen_t     rs1_val,
    input  lsu_pkg::xlen_t     rs2_val,
    input  logic               read_busy,
    input  logic               write_busy,
    output logic               ld_misaligned,
    output logic               st_misaligned,
    lsu_req_if.issuer          ld_req,
    lsu_req_if.issuer          st_req
);

    import lsu_pkg::*;

    issue_state_t state;
    issue_state_t state_nxt;

    xlen_t        eff_addr;
    logic         is_load;
    logic         is_store;
    logic         misal;

    // Instruction held while ordering or the path stalls it
    xlen_t        hold_addr;
    funct3_t      hold_funct3;
    reg_addr_t    hold_rd;
    xlen_t        hold_data;
    logic         hold_load;
    logic         hold_store;

    // Request currently presented to the paths
    logic         cur_act;
    logic         cur_load;
    logic         cur_store;
    logic         order_ok;
    logic         req_fire;

    ////////////////////////////////////////
    // Decode and address
    ////////////////////////////////////////

    // rs1 plus sign-extended immediate
    assign eff_addr = rs1_val + {{(XLEN_C-12){inst_imm[11]}}, inst_imm};
    assign is_load  = (inst_opcode == OPC_LOAD);
    assign is_store = (inst_opcode == OPC_STORE);

    // Half-words need an even offset, words a zero offset
    always_comb begin
        misal = 1'b0;
        if (inst_funct3 == F3_H || inst_funct3 == F3_HU) begin
            misal = eff_addr[0];
        end else if (inst_funct3 == F3_W) begin
            misal = |eff_addr[1:0];
        end
    end

    // Only accepts from IDLE, the held slot is then free
    assign inst_ready = (state == IDLE);

    ////////////////////////////////////////
    // Request selection and ordering
    ////////////////////////////////////////

    // Live instruction in IDLE, held copy otherwise
    assign cur_act   = (state == IDLE) ? inst_valid : 1'b1;
    assign cur_load  = (state == IDLE) ? is_load    : hold_load;
    assign cur_store = (state == IDLE) ? is_store   : hold_store;

    // Loads wait out writes, stores wait out reads
    assign order_ok = cur_load ? !write_busy : !read_busy;

    assign ld_req.valid  = cur_act & cur_load & !write_busy;
    assign st_req.valid  = cur_act & cur_store & !read_busy;

    assign ld_req.addr   = (state == IDLE) ? eff_addr    : hold_addr;
    assign st_req.addr   = (state == IDLE) ? eff_addr    : hold_addr;
    assign ld_req.funct3 = (state == IDLE) ? inst_funct3 : hold_funct3;
    assign st_req.funct3 = (state == IDLE) ? inst_funct3 : hold_funct3;
    assign ld_req.rd     = (state == IDLE) ? inst_rd     : hold_rd;
    assign st_req.rd     = (state == IDLE) ? inst_rd     : hold_rd;
    assign ld_req.data   = (state == IDLE) ? rs2_val     : hold_data;
    assign st_req.data   = (state == IDLE) ? rs2_val     : hold_data;

    assign req_fire = (ld_req.valid & ld_req.ready) | (st_req.valid & st_req.ready);

    ////////////////////////////////////////
    // Issue FSM
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // Accepted but not handed over this cycle
                if (inst_valid && (is_load || is_store) && !req_fire) begin
                    state_nxt = order_ok ? WAIT_PATH : WAIT_ORDER;
                end
            end
            WAIT_ORDER: begin
                if (req_fire) begin
                    state_nxt = IDLE;
                end else if (order_ok) begin
                    state_nxt = WAIT_PATH;
                end
            end
            WAIT_PATH: begin
                if (req_fire) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state         <= IDLE;
            ld_misaligned <= 1'b0;
            st_misaligned <= 1'b0;
        end else begin
            state         <= state_nxt;
            // One-cycle pulse after acceptance
            ld_misaligned <= inst_valid & inst_ready & is_load & misal;
            st_misaligned <= inst_valid & inst_ready & is_store & misal;
        end
    end

    // Capture on every accepted instruction
    always_ff @(posedge aclk) begin
        if (inst_valid && inst_ready) begin
            hold_addr   <= eff_addr;
            hold_funct3 <= inst_funct3;
            hold_rd     <= inst_rd;
            hold_data   <= rs2_val;
            hold_load   <= is_load;
            hold_store  <= is_store;
        end
    end

endmodule

// File: lsu_load_path.sv
`timescale 1ns/1ps
/* LSU load path: AXI4-lite AR/R channels, FIFO of outstanding loads
   and registered register write-back with sign or zero extension */
module lsu_load_path #(
    parameter int MAX_OR = 4
) (
    input  logic               aclk,
    input  logic               aresetn,
    lsu_req_if.server          ld_req,
    output logic               arvalid,
    input  logic               arready,
    output lsu_pkg::xlen_t     araddr,
    input  logic               rvalid,
    output logic               rready,
    input  logic [1:0]         rresp,
    input  lsu_pkg::xlen_t     rdata,
    output logic               rd_wr,
    output lsu_pkg::reg_addr_t rd_addr,
    output lsu_pkg::xlen_t     rd_val,
    output logic               read_busy
);

    import lsu_pkg::*;

    localparam int PTR_W = $clog2(MAX_OR);
    localparam int CNT_W = PTR_W + 1;

    // Per-load context kept until its R beat
    reg_addr_t        fifo_rd  [MAX_OR];
    funct3_t          fifo_f3  [MAX_OR];
    offset_t          fifo_off [MAX_OR];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;
    logic             fifo_full;
    logic             push;
    logic             pop;

    assign fifo_full = (fifo_cnt == CNT_W'(MAX_OR));
    // Held low while AR is pending or every slot is taken
    assign ld_req.ready = !arvalid & !fifo_full;
    assign push = ld_req.valid & ld_req.ready;

    // Always accept read data, rresp not checked
    assign rready = 1'b1;
    assign pop = rvalid & rready;

    assign read_busy = (fifo_cnt != '0);

    ////////////////////////////////////////
    // AR channel
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            arvalid <= 1'b0;
        end else if (push) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            araddr <= ld_req.addr;
        end
    end

    ////////////////////////////////////////
    // Outstanding load FIFO
    ////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (push) begin
            fifo_rd[wr_ptr]  <= ld_req.rd;
            fifo_f3[wr_ptr]  <= ld_req.funct3;
            fifo_off[wr_ptr] <= ld_req.addr[1:0];
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            // Count moves only when push and pop differ
            if (push && !pop) begin
                fifo_cnt <= fifo_cnt + 1'b1;
            end else if (!push && pop) begin
                fifo_cnt <= fifo_cnt - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Register write-back
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_wr <= 1'b0;
        end else begin
            rd_wr <= pop;
        end
    end

    // Head entry describes the beat being returned
    always_ff @(posedge aclk) begin
        if (pop) begin
            rd_addr <= fifo_rd[rd_ptr];
            rd_val  <= load_value(fifo_f3[rd_ptr], rdata, fifo_off[rd_ptr]);
        end
    end

endmodule

// File: lsu_pkg.sv
/* LSU shared definitions: widths, RV32 opcodes and funct3 codes,
   store alignment and load extraction helpers */
package lsu_pkg;

    localparam int XLEN_C = 32;

    typedef logic [XLEN_C-1:0]   xlen_t;
    typedef logic [XLEN_C/8-1:0] strb_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [6:0]          opcode_t;
    typedef logic [2:0]          funct3_t;
    typedef logic [1:0]          offset_t;
    typedef logic [11:0]         imm12_t;

    // RV32I major opcodes
    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // Access size and sign, shared by loads and stores (SB/SH/SW use B/H/W)
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ORDER,
        WAIT_PATH
    } issue_state_t;

    // Place rs2 on the byte lanes selected by the address offset
    function automatic xlen_t store_wdata(xlen_t rs2, offset_t off);
        return rs2 << {off, 3'b000};
    endfunction

    // Byte enables for SB/SH/SW, upper lanes past bit 3 drop out
    function automatic strb_t store_strb(funct3_t f3, offset_t off);
        strb_t base;
        case (f3)
            F3_B:    base = 4'b0001;
            F3_H:    base = 4'b0011;
            default: base = 4'b1111;
        endcase
        return strb_t'(base << off);
    endfunction

    // Pick the addressed byte or half-word and extend it to 32 bits
    function automatic xlen_t load_value(funct3_t f3, xlen_t word, offset_t off);
        xlen_t sh;
        sh = word >> {off, 3'b000};
        case (f3)
            F3_B:    return {{24{sh[7]}}, sh[7:0]};
            F3_H:    return {{16{sh[15]}}, sh[15:0]};
            F3_BU:   return {24'd0, sh[7:0]};
            F3_HU:   return {16'd0, sh[15:0]};
            default: return word;
        endcase
    endfunction

endpackage

// File: lsu_req_if.sv
`timescale 1ns/1ps
/* Issued memory request from the issue control to one path,
   valid/ready handshake with address, size code, destination and store data */
interface lsu_req_if;

    import lsu_pkg::*;

    // Handshake
    logic      valid;
    logic      ready;

    // Payload, stable while valid is high
    xlen_t     addr;
    funct3_t   funct3;
    // Destination register, loads only
    reg_addr_t rd;
    // Raw rs2 value, stores only
    xlen_t     data;

    modport issuer (
        output valid, addr, funct3, rd, data,
        input  ready
    );

    modport server (
        input  valid, addr, funct3, rd, data,
        output ready
    );

endinterface

// File: lsu_store_path.sv
`timescale 1ns/1ps
/* LSU store path: AXI4-lite AW/W/B channels with aligned data and
   strobes, and a count of writes still waiting for their response */
module lsu_store_path #(
    parameter int MAX_OR = 4
) (
    input  logic           aclk,
    input  logic           aresetn,
    lsu_req_if.server      st_req,
    output logic           awvalid,
    input  logic           awready,
    output lsu_pkg::xlen_t awaddr,
    output logic           wvalid,
    input  logic           wready,
    output lsu_pkg::xlen_t wdata,
    output lsu_pkg::strb_t wstrb,
    input  logic           bvalid,
    output logic           bready,
    input  logic [1:0]     bresp,
    output logic           write_busy
);

    import lsu_pkg::*;

    localparam int CNT_W = $clog2(MAX_OR) + 1;

    logic [CNT_W-1:0] wr_cnt;
    logic             wr_full;
    logic             req_fire;
    logic             b_fire;

    assign wr_full  = (wr_cnt == CNT_W'(MAX_OR));
    // Next request only once both AW and W of the last one are gone
    assign st_req.ready = !awvalid & !wvalid & !wr_full;
    assign req_fire = st_req.valid & st_req.ready;

    // Responses always taken, bresp not checked
    assign bready = 1'b1;
    assign b_fire = bvalid & bready;

    assign write_busy = (wr_cnt != '0);

    ////////////////////////////////////////
    // AW and W channels
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (req_fire) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            // Each channel drops on its own handshake
            if (awready) awvalid <= 1'b0;
            if (wready)  wvalid  <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_fire) begin
            awaddr <= st_req.addr;
            wdata  <= store_wdata(st_req.data, st_req.addr[1:0]);
            wstrb  <= store_strb(st_req.funct3, st_req.addr[1:0]);
        end
    end

    ////////////////////////////////////////
    // Outstanding write counter
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_cnt <= '0;
        end else if (req_fire && !b_fire) begin
            wr_cnt <= wr_cnt + 1'b1;
        end else if (!req_fire && b_fire) begin
            wr_cnt <= wr_cnt - 1'b1;
        end
    end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps
/* RV32 load/store unit top: issue control feeding parallel load and
   store paths, AXI4-lite master toward data memory */
module lsu_top #(
    parameter int MAX_OR = 4
) (
    input  logic               aclk,
    input  logic               aresetn,
    // Instruction side
    input  logic               inst_valid,
    output logic               inst_ready,
    input  lsu_pkg::opcode_t   inst_opcode,
    input  lsu_pkg::funct3_t   inst_funct3,
    input  lsu_pkg::reg_addr_t inst_rd,
    input  lsu_pkg::imm12_t    inst_imm,
    input  lsu_pkg::xlen_t     rs1_val,
    input  lsu_pkg::xlen_t     rs2_val,
    // Result side
    output logic               rd_wr,
    output lsu_pkg::reg_addr_t rd_addr,
    output lsu_pkg::xlen_t     rd_val,
    output logic               ld_misaligned,
    output logic               st_misaligned,
    output logic               pending_read,
    output logic               pending_write,
    // AXI4-lite write channels
    output logic               awvalid,
    input  logic               awready,
    output lsu_pkg::xlen_t     awaddr,
    output logic               wvalid,
    input  logic               wready,
    output lsu_pkg::xlen_t     wdata,
    output lsu_pkg::strb_t     wstrb,
    input  logic               bvalid,
    output logic               bready,
    input  logic [1:0]         bresp,
    // AXI4-lite read channels
    output logic               arvalid,
    input  logic               arready,
    output lsu_pkg::xlen_t     araddr,
    input  logic               rvalid,
    output logic               rready,
    input  logic [1:0]         rresp,
    input  lsu_pkg::xlen_t     rdata
);

    lsu_req_if ld_req ();
    lsu_req_if st_req ();

    // Busy flags double as the pending outputs
    lsu_issue_ctrl u_issue_ctrl (
        .aclk, .aresetn, .inst_valid, .inst_ready, .inst_opcode, .inst_funct3,
        .inst_rd, .inst_imm, .rs1_val, .rs2_val,
        .read_busy     (pending_read),
        .write_busy    (pending_write),
        .ld_misaligned, .st_misaligned,
        .ld_req        (ld_req.issuer),
        .st_req        (st_req.issuer)
    );

    lsu_store_path #(.MAX_OR(MAX_OR)) u_store_path (
        .aclk, .aresetn,
        .st_req        (st_req.server),
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .write_busy    (pending_write)
    );

    lsu_load_path #(.MAX_OR(MAX_OR)) u_load_path (
        .aclk, .aresetn,
        .ld_req        (ld_req.server),
        .arvalid, .arready, .araddr, .rvalid, .rready, .rresp, .rdata,
        .rd_wr, .rd_addr, .rd_val,
        .read_busy     (pending_read)
    );

endmodule

// File: sim.f
lsu_pkg.sv
lsu_req_if.sv
lsu_issue_ctrl.sv
lsu_store_path.sv
lsu_load_path.sv
lsu_top.sv
tb_lsu_chk.sv
tb_lsu.sv

// File: tb_lsu.sv
`timescale 1ns/1ps
/* Testbench for lsu_top: case file driven instructions, random-latency
   AXI4-lite slave, in-order result and ordering checks */
module tb_lsu;

    import lsu_pkg::*;

    localparam int MAXC = 64;

    logic aclk = 1'b0;
    logic aresetn;
    logic inst_valid, inst_ready, rd_wr, ld_misaligned, st_misaligned;
    logic pending_read, pending_write;
    opcode_t inst_opcode;
    funct3_t inst_funct3;
    reg_addr_t inst_rd, rd_addr;
    imm12_t inst_imm;
    xlen_t rs1_val, rs2_val, rd_val, awaddr, wdata, araddr, rdata;
    strb_t wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;

    // Case table, one row per instruction
    logic [31:0] c_op[MAXC], c_f3[MAXC], c_rd[MAXC], c_imm[MAXC], c_rs1[MAXC], c_rs2[MAXC];
    logic [31:0] c_rdat[MAXC], c_exp[MAXC], c_strb[MAXC], c_lm[MAXC], c_sm[MAXC];

    // Expected traffic, in issue order
    xlen_t exp_aw_q[$], exp_w_q[$], exp_ar_q[$], ld_val_q[$], rdata_q[$];
    strb_t exp_strb_q[$];
    reg_addr_t ld_rd_q[$];
    int st_id_q[$], ld_id_q[$];

    int n_cases, n_st, n_ld, errors, checks, cycles, limit, seed;
    int aw_hs, w_hs, b_hs, ar_hs, r_hs, wb_cnt;
    int aw_wait, w_wait, ar_wait, b_gap, r_gap;
    logic b_done, r_done, exp_lm, exp_sm, cur_lm, cur_sm;

    lsu_top #(.MAX_OR(4)) u_lsu_top (.*);

    bind lsu_top tb_lsu_chk u_chk (.*);

    always #20 aclk = ~aclk;

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // Run limit scales with the case count
    always @(posedge aclk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Run timed out after %0d cycles, DUT stopped responding", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // AXI slave model
    ////////////////////////////////////////

    always @(posedge aclk) begin
        if (aresetn && awvalid && awready) begin
            aw_hs++;
            check_val(32'(ar_hs - r_hs), 32'd0, "AW issued while read outstanding");
            check_val(awaddr, exp_aw_q.pop_front(), "awaddr");
        end
        #1;
        if (!awvalid) begin
            awready = 1'b0;
            aw_wait = $random(seed) & 3;
        end else if (aw_wait == 0) begin
            awready = 1'b1;
        end else begin
            awready = 1'b0;
            aw_wait--;
        end
    end

    always @(posedge aclk) begin
        if (aresetn && wvalid && wready) begin
            w_hs++;
            check_val(wdata, exp_w_q.pop_front(), "wdata");
            check_val(32'(wstrb), 32'(exp_strb_q.pop_front()), "wstrb");
            $display("case %0d store done", st_id_q.pop_front());
        end
        #1;
        if (!wvalid) begin
            wready = 1'b0;
            w_wait = $random(seed) & 3;
        end else if (w_wait == 0) begin
            wready = 1'b1;
        end else begin
            wready = 1'b0;
            w_wait--;
        end
    end

    always @(posedge aclk) begin
        if (aresetn && arvalid && arready) begin
            ar_hs++;
            check_val(32'(aw_hs - b_hs), 32'd0, "AR issued while write outstanding");
            check_val(araddr, exp_ar_q.pop_front(), "araddr");
        end
        #1;
        if (!arvalid) begin
            arready = 1'b0;
            ar_wait = $random(seed) & 3;
        end else if (ar_wait == 0) begin
            arready = 1'b1;
        end else begin
            arready = 1'b0;
            ar_wait--;
        end
    end

    // One B per write whose AW and W are both done
    always @(posedge aclk) begin
        b_done = aresetn && bvalid && bready;
        if (b_done) b_hs++;
        #1;
        if (b_done) bvalid = 1'b0;
        if (!bvalid && ((aw_hs < w_hs) ? aw_hs : w_hs) > b_hs) begin
            if (b_gap == 0) begin
                bvalid = 1'b1;
                b_gap = $random(seed) & 3;
            end else begin
                b_gap--;
            end
        end
    end

    // Read data returned in AR order
    always @(posedge aclk) begin
        r_done = aresetn && rvalid && rready;
        if (r_done) r_hs++;
        #1;
        if (r_done) rvalid = 1'b0;
        if (!rvalid && ar_hs > r_hs && rdata_q.size() > 0) begin
            if (r_gap == 0) begin
                rvalid = 1'b1;
                rdata = rdata_q.pop_front();
                r_gap = $random(seed) & 3;
            end else begin
                r_gap--;
            end
        end
    end

    ////////////////////////////////////////
    // Result monitors
    ////////////////////////////////////////

    always @(posedge aclk) begin
        if (aresetn && rd_wr) begin
            wb_cnt++;
            if (ld_rd_q.size() == 0) begin
                errors++;
                $display("Register write-back at %0t with no load outstanding", $time);
            end else begin
                check_val(32'(rd_addr), 32'(ld_rd_q.pop_front()), "rd_addr");
                check_val(rd_val, ld_val_q.pop_front(), "rd_val");
                $display("case %0d load done", ld_id_q.pop_front());
            end
        end
    end

    // Exception pulse exactly one cycle after acceptance
    always @(negedge aclk) begin
        if (aresetn) begin
            check_val(32'(ld_misaligned), 32'(exp_lm), "ld_misaligned");
            check_val(32'(st_misaligned), 32'(exp_sm), "st_misaligned");
            exp_lm = inst_valid && inst_ready && cur_lm;
            exp_sm = inst_valid && inst_ready && cur_sm;
        end
    end

    ////////////////////////////////////////
    // Case reader and driver
    ////////////////////////////////////////

    task automatic read_cases();
        int fd;
        int rc;
        string line;
        fd = $fopen("lsu_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file lsu_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_cases < MAXC) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        c_op[n_cases], c_f3[n_cases], c_rd[n_cases], c_imm[n_cases],
                        c_rs1[n_cases], c_rs2[n_cases], c_rdat[n_cases], c_exp[n_cases],
                        c_strb[n_cases], c_lm[n_cases], c_sm[n_cases]);
                    if (rc == 11) n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue_case(input int i);
        xlen_t addr;
        // Effective address, sign-extended 12-bit immediate
        addr = c_rs1[i] + {{20{c_imm[i][11]}}, c_imm[i][11:0]};
        inst_opcode = opcode_t'(c_op[i]);
        inst_funct3 = funct3_t'(c_f3[i]);
        inst_rd     = reg_addr_t'(c_rd[i]);
        inst_imm    = imm12_t'(c_imm[i]);
        rs1_val     = c_rs1[i];
        rs2_val     = c_rs2[i];
        cur_lm      = c_lm[i][0];
        cur_sm      = c_sm[i][0];
        if (inst_opcode == OPC_STORE) begin
            n_st++;
            exp_aw_q.push_back(addr);
            exp_w_q.push_back(c_exp[i]);
            exp_strb_q.push_back(strb_t'(c_strb[i]));
            st_id_q.push_back(i);
        end else begin
            n_ld++;
            exp_ar_q.push_back(addr);
            ld_rd_q.push_back(reg_addr_t'(c_rd[i]));
            ld_val_q.push_back(c_exp[i]);
            ld_id_q.push_back(i);
            rdata_q.push_back(c_rdat[i]);
        end
        inst_valid = 1'b1;
        while (!inst_ready) begin
            @(posedge aclk);
            #1;
        end
        @(posedge aclk);
        #1;
        inst_valid = 1'b0;
    endtask

    initial begin
        aresetn = 1'b0;
        inst_valid = 1'b0;
        inst_opcode = '0;
        inst_funct3 = '0;
        inst_rd = '0;
        inst_imm = '0;
        rs1_val = '0;
        rs2_val = '0;
        awready = 1'b0;
        wready = 1'b0;
        arready = 1'b0;
        bvalid = 1'b0;
        rvalid = 1'b0;
        bresp = 2'b00;
        rresp = 2'b00;
        rdata = '0;
        seed = 53;
        {exp_lm, exp_sm, cur_lm, cur_sm} = 4'b0000;
        read_cases();
        limit = 50 * n_cases + 100;
        repeat (4) @(posedge aclk);
        #1;
        // Idle outputs straight out of reset
        check_val(32'({awvalid, wvalid, arvalid, rd_wr, ld_misaligned, st_misaligned,
            pending_read, pending_write}), 32'd0, "outputs after reset");
        check_val(32'(inst_ready), 32'd1, "inst_ready after reset");
        aresetn = 1'b1;
        for (int i = 0; i < n_cases; i++) begin
            issue_case(i);
        end
        while (ld_rd_q.size() > 0 || st_id_q.size() > 0 || pending_read || pending_write) begin
            @(posedge aclk);
        end
        repeat (2) @(posedge aclk);
        check_val(32'(aw_hs), 32'(n_st), "AW count");
        check_val(32'(b_hs), 32'(n_st), "B count");
        check_val(32'(ar_hs), 32'(n_ld), "AR count");
        check_val(32'(wb_cnt), 32'(n_ld), "write-back count");
        if (u_lsu_top.u_chk.fail_cnt > 0) begin
            $display("Bound checker saw %0d failed assertions", u_lsu_top.u_chk.fail_cnt);
        end
        errors += u_lsu_top.u_chk.fail_cnt;
        $display("cases %0d, checks %0d, errors %0d", n_cases, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb_lsu_chk.sv
`timescale 1ns/1ps
/* AXI4-lite handshake and read/write ordering checker, bound into lsu_top */
module tb_lsu_chk (
    input logic           aclk,
    input logic           aresetn,
    input logic           awvalid,
    input logic           awready,
    input lsu_pkg::xlen_t awaddr,
    input logic           wvalid,
    input logic           wready,
    input lsu_pkg::xlen_t wdata,
    input lsu_pkg::strb_t wstrb,
    input logic           arvalid,
    input logic           arready,
    input lsu_pkg::xlen_t araddr,
    input logic           pending_read,
    input logic           pending_write
);

    // Count of failed assertions
    int fail_cnt = 0;

    // Valid holds with a stable payload until ready
    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("AW dropped or changed before awready");
            fail_cnt++;
        end
    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else begin
            $error("W dropped or changed before wready");
            fail_cnt++;
        end
    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("AR dropped or changed before arready");
            fail_cnt++;
        end

    // Direction blocking
    ar_order: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(arvalid) |-> !pending_write)
        else begin
            $error("AR raised while a write is outstanding");
            fail_cnt++;
        end
    aw_order: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(awvalid) |-> !pending_read)
        else begin
            $error("AW raised while a read is outstanding");
            fail_cnt++;
        end

endmodule
